// File: bench/blur_model.svh
`ifndef BLUR_MODEL_SVH
`define BLUR_MODEL_SVH

// Pixels of up to two frames in raster order
logic [11:0] frame_mem [frame_slots];
// Expected output beats as {sop, eop, pixel}
logic [13:0] exp_q [$];

// Full 5x5 blur weights, symmetric so tap orientation does not matter
localparam int weight_5x5 [5][5] = '{
    '{1, 2, 3, 2, 1},
    '{2, 3, 4, 3, 2},
    '{3, 4, 4, 4, 3},
    '{2, 3, 4, 3, 2},
    '{1, 2, 3, 2, 1}
};

// Code 3 behaves as 1x1
function automatic int kernel_side(input logic [1:0] sel);
    case (sel)
        sel_5x5: return 5;
        sel_3x3: return 3;
        default: return 1;
    endcase
endfunction

// Offsets count back from the newest row and column
function automatic int tap_weight(input int side, input int dr, input int dc);
    if (side == 1) begin
        return (dr == 0 && dc == 0) ? 1 : 0;
    end
    return weight_5x5[dr + (5 - side) / 2][dc + (5 - side) / 2];
endfunction

function automatic logic [11:0] blurred_pixel(input int base, input int row, input int col,
                                              input int side);
    int acc;
    int wsum;
    int sh;
    int w;
    logic [11:0] pix;
    pix = '0;
    for (int ch = 0; ch < 3; ch++) begin
        acc = 0;
        wsum = 0;
        for (int dr = 0; dr < side; dr++) begin
            for (int dc = 0; dc < side; dc++) begin
                w = tap_weight(side, dr, dc);
                wsum += w;
                // Taps above the frame or left of the line count as zero
                if (row >= dr && col >= dc) begin
                    acc += w * int'(frame_mem[base + (row - dr) * img_width + col - dc][ch*4 +: 4]);
                end
            end
        end
        sh = 0;
        while ((1 << sh) < wsum) begin
            sh++;
        end
        pix[ch*4 +: 4] = 4'(acc >> sh);
    end
    return pix;
endfunction

task automatic queue_expected(input int base, input int height, input logic [1:0] sel);
    int side;
    int count;
    side = kernel_side(sel);
    count = height * img_width;
    for (int p = 0; p < count; p++) begin
        exp_q.push_back({p == 0, p == count - 1,
                         blurred_pixel(base, p / img_width, p % img_width, side)});
    end
endtask

`endif

// File: bench/blur_filter_tb.sv
`timescale 1ns/1ps

module blur_filter_tb;
    import blur_pkg::*;

    localparam int img_width = 8;
    localparam int frame_slots = 2 * img_width * 6;
    // 32 + 32 + 48 + 32 + 64 + 32 beats over the six tests
    localparam int total_beats = 240;
    localparam int cycle_limit = 20 * total_beats;

    logic clk = 1'b0;
    logic rst_n;
    logic [1:0] kernel_sel;
    logic valid_in;
    logic ready_in;
    logic sop_in;
    logic eop_in;
    logic [pixel_w-1:0] data_in;
    logic valid_out;
    logic ready_out = 1'b1;
    logic sop_out;
    logic eop_out;
    logic [pixel_w-1:0] data_out;

    logic bp_en = 1'b0;
    logic lat_check = 1'b1;
    int edge_cnt = 0;
    int err_cnt = 0;
    int check_cnt = 0;
    int test_cnt = 0;
    // Edge on which each input beat was taken
    int acc_q [$];

    `include "blur_model.svh"

    blur_filter #(
        .IMG_WIDTH(img_width)
    ) uut (
        .clk(clk),
        .rst_n(rst_n),
        .kernel_sel(kernel_sel),
        .valid_in(valid_in),
        .ready_in(ready_in),
        .sop_in(sop_in),
        .eop_in(eop_in),
        .data_in(data_in),
        .valid_out(valid_out),
        .ready_out(ready_out),
        .sop_out(sop_out),
        .eop_out(eop_out),
        .data_out(data_out)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
        if (edge_cnt >= cycle_limit) begin
            $display("Timed out after %0d cycles while waiting for output beats", edge_cnt);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Random stalls only while back-pressure is enabled
    always @(posedge clk) begin
        #1;
        ready_out = bp_en ? ($urandom % 2 != 0) : 1'b1;
    end

    // Both handshakes are sampled mid-cycle, where they are stable
    always @(negedge clk) begin : collect
        logic [13:0] exp_beat;
        int acc_edge;
        if (valid_in && ready_in) begin
            acc_q.push_back(edge_cnt + 1);
        end
        if (rst_n && valid_out && ready_out) begin
            assert (exp_q.size() > 0) else begin
                $display("Unexpected output beat at %0t with no pixel left to expect", $time);
                err_cnt++;
            end
            if (exp_q.size() > 0) begin
                exp_beat = exp_q.pop_front();
                acc_edge = -1;
                if (acc_q.size() > 0) begin
                    acc_edge = acc_q.pop_front();
                end
                check_cnt++;
                assert (data_out == exp_beat[11:0] && sop_out == exp_beat[13]
                        && eop_out == exp_beat[12]) else begin
                    $display("[FAIL] %0t: got %h sop %b eop %b, expected %h sop %b eop %b",
                             $time, data_out, sop_out, eop_out,
                             exp_beat[11:0], exp_beat[13], exp_beat[12]);
                    err_cnt++;
                end
                if (lat_check) begin
                    assert (edge_cnt - acc_edge == 4) else begin
                        $display("[FAIL] %0t: latency of %0d edges, expected 4",
                                 $time, edge_cnt - acc_edge);
                        err_cnt++;
                    end
                end
            end
        end
    end

    task automatic fill_random(input int base, input int count);
        for (int i = 0; i < count; i++) begin
            frame_mem[base + i] = 12'($urandom);
        end
    endtask

    task automatic fill_flat(input int base, input int count, input logic [11:0] value);
        for (int i = 0; i < count; i++) begin
            frame_mem[base + i] = value;
        end
    endtask

    // Called at 1 ns after an edge, returns at the same point
    task automatic send_frame(input int base, input int height, input logic [1:0] sel,
                              input int max_gap);
        int count;
        int gap;
        logic taken;
        count = height * img_width;
        kernel_sel = sel;
        for (int p = 0; p < count; p++) begin
            gap = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
            valid_in = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            valid_in = 1'b1;
            sop_in = (p == 0);
            eop_in = (p == count - 1);
            data_in = frame_mem[base + p];
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = ready_in;
                @(posedge clk);
                #1;
            end
        end
        valid_in = 1'b0;
        sop_in = 1'b0;
        eop_in = 1'b0;
    endtask

    task automatic wait_outputs();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int beats, input int err_start);
        test_cnt++;
        if (err_cnt == err_start) begin
            $display("%s: ok, %0d beats", name, beats);
        end else begin
            $display("%s: %0d errors over %0d beats", name, err_cnt - err_start, beats);
        end
    endtask

    task automatic passthrough_1x1();
        int err_start;
        err_start = err_cnt;
        fill_random(0, 32);
        // Every pixel should come out as it went in
        for (int p = 0; p < 32; p++) begin
            exp_q.push_back({p == 0, p == 31, frame_mem[p]});
        end
        send_frame(0, 4, sel_1x1, 0);
        wait_outputs();
        report_test("1x1 passthrough", 32, err_start);
    endtask

    task automatic blur_3x3_random();
        int err_start;
        err_start = err_cnt;
        fill_random(0, 32);
        queue_expected(0, 4, sel_3x3);
        send_frame(0, 4, sel_3x3, 0);
        wait_outputs();
        report_test("3x3 random frame", 32, err_start);
    endtask

    // Interior pixels of a flat 0xF frame must stay 0xFFF
    task automatic blur_5x5_flat();
        int err_start;
        err_start = err_cnt;
        fill_flat(0, 48, 12'hfff);
        queue_expected(0, 6, sel_5x5);
        send_frame(0, 6, sel_5x5, 0);
        wait_outputs();
        report_test("5x5 flat frame", 48, err_start);
    endtask

    task automatic ready_backpressure();
        int err_start;
        err_start = err_cnt;
        lat_check = 1'b0;
        bp_en = 1'b1;
        fill_random(0, 32);
        queue_expected(0, 4, sel_3x3);
        send_frame(0, 4, sel_3x3, 0);
        wait_outputs();
        bp_en = 1'b0;
        @(posedge clk);
        #1;
        lat_check = 1'b1;
        report_test("3x3 with back-pressure", 32, err_start);
    endtask

    // Second frame starts right after the first, with a new kernel
    task automatic frames_back_to_back();
        int err_start;
        err_start = err_cnt;
        fill_random(0, 32);
        fill_random(48, 32);
        queue_expected(0, 4, sel_3x3);
        queue_expected(48, 4, sel_5x5);
        send_frame(0, 4, sel_3x3, 0);
        send_frame(48, 4, sel_5x5, 0);
        wait_outputs();
        report_test("back-to-back 3x3 then 5x5", 64, err_start);
    endtask

    task automatic latency_with_gaps();
        int err_start;
        err_start = err_cnt;
        fill_random(0, 32);
        queue_expected(0, 4, sel_3x3);
        send_frame(0, 4, sel_3x3, 3);
        wait_outputs();
        report_test("latency with input gaps", 32, err_start);
    endtask

    initial begin
        void'($urandom(32'haca0_f1f1));
        rst_n = 1'b0;
        kernel_sel = sel_1x1;
        valid_in = 1'b0;
        sop_in = 1'b0;
        eop_in = 1'b0;
        data_in = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        passthrough_1x1();
        blur_3x3_random();
        blur_5x5_flat();
        ready_backpressure();
        frames_back_to_back();
        latency_with_gaps();

        // Idle time lets any stray extra beat reach the collector
        repeat (10) @(posedge clk);
        $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/blur_filter.sv
`timescale 1ns/1ps

module blur_filter #(
    parameter int IMG_WIDTH = 320
) (
    input  logic clk,
    input  logic rst_n,
    input  logic [1:0] kernel_sel,
    input  logic valid_in,
    output logic ready_in,
    input  logic sop_in,
    input  logic eop_in,
    input  logic [blur_pkg::pixel_w-1:0] data_in,
    output logic valid_out,
    input  logic ready_out,
    output logic sop_out,
    output logic eop_out,
    output logic [blur_pkg::pixel_w-1:0] data_out
);
    import blur_pkg::*;

    localparam int n_chan = pixel_w / chan_w;

    logic advance;
    logic [1:0] sel_q;
    logic [1:0] sel_win;
    logic [win_size-1:0][win_size-1:0][pixel_w-1:0] win_taps;
    logic win_valid;
    logic win_sop;
    logic win_eop;
    logic [win_size-1:0][win_size-1:0][chan_w-1:0] ch_taps [n_chan];
    logic [chan_w-1:0] ch_out [n_chan];

    assign ready_in = advance;

    // Kernel is fixed per frame and follows the frame down the pipeline
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_q <= sel_1x1;
            sel_win <= sel_1x1;
        end else if (advance) begin
            if (valid_in && sop_in) begin
                sel_q <= kernel_sel;
            end
            sel_win <= sel_q;
        end
    end

    pixel_window #(
        .IMG_WIDTH(IMG_WIDTH)
    ) u_window (
        .clk(clk),
        .rst_n(rst_n),
        .advance(advance),
        .valid_in(valid_in),
        .sop_in(sop_in),
        .eop_in(eop_in),
        .data_in(data_in),
        .taps(win_taps),
        .win_valid(win_valid),
        .win_sop(win_sop),
        .win_eop(win_eop)
    );

    // Channel 0 is blue in the low bits, channel 2 is red
    for (genvar g = 0; g < n_chan; g++) begin : g_chan
        for (genvar r = 0; r < win_size; r++) begin : g_row
            for (genvar c = 0; c < win_size; c++) begin : g_col
                assign ch_taps[g][r][c] = win_taps[r][c][g*chan_w +: chan_w];
            end
        end

        channel_convolver u_conv (
            .clk(clk),
            .rst_n(rst_n),
            .advance(advance),
            .kernel_sel(sel_win),
            .taps(ch_taps[g]),
            .chan_out(ch_out[g])
        );
    end

    stream_packer u_packer (
        .clk(clk),
        .rst_n(rst_n),
        .win_valid(win_valid),
        .win_sop(win_sop),
        .win_eop(win_eop),
        .chan_r(ch_out[2]),
        .chan_g(ch_out[1]),
        .chan_b(ch_out[0]),
        .ready_out(ready_out),
        .advance(advance),
        .valid_out(valid_out),
        .sop_out(sop_out),
        .eop_out(eop_out),
        .data_out(data_out)
    );

endmodule

// File: hdl/blur_pkg.sv
package blur_pkg;

    localparam int pixel_w = 12;
    localparam int chan_w = 4;
    localparam int win_size = 5;
    localparam int acc_w = 11;

    // kernel_sel codes, 3 falls back to 1x1
    localparam logic [1:0] sel_1x1 = 2'd0;
    localparam logic [1:0] sel_3x3 = 2'd1;
    localparam logic [1:0] sel_5x5 = 2'd2;

    // Row and column offset 0 is the newest tap
    function automatic logic [2:0] kernel_weight(input logic [1:0] sel, input int row,
                                                 input int col);
        int k;
        int r;
        int c;
        int dr;
        int dc;
        int w;
        case (sel)
            sel_5x5: k = 5;
            sel_3x3: k = 3;
            default: k = 1;
        endcase
        // Smaller kernels take the centre of the 5x5 table
        r = row + (win_size - k) / 2;
        c = col + (win_size - k) / 2;
        dr = (r <= 2) ? r : 4 - r;
        dc = (c <= 2) ? c : 4 - c;
        w = (dr + dc + 1 > 4) ? 4 : dr + dc + 1;
        if (k == 1) begin
            w = 1;
        end
        if (row >= k || col >= k) begin
            w = 0;
        end
        return 3'(w);
    endfunction

    function automatic logic [2:0] norm_shift(input logic [1:0] sel);
        case (sel)
            sel_5x5: return 3'd6;
            sel_3x3: return 3'd5;
            default: return 3'd0;
        endcase
    endfunction

endpackage

// File: hdl/channel_convolver.sv
`timescale 1ns/1ps

module channel_convolver (
    input  logic clk,
    input  logic rst_n,
    input  logic advance,
    input  logic [1:0] kernel_sel,
    input  logic [blur_pkg::win_size-1:0][blur_pkg::win_size-1:0][blur_pkg::chan_w-1:0] taps,
    output logic [blur_pkg::chan_w-1:0] chan_out
);
    import blur_pkg::*;

    logic [acc_w-1:0] row_sum_d [win_size];
    logic [acc_w-1:0] row_sum_q [win_size];
    logic [acc_w-1:0] total;
    logic [2:0] shift_q;

    // Weighted sum along each window row
    always_comb begin
        for (int r = 0; r < win_size; r++) begin
            row_sum_d[r] = '0;
            for (int c = 0; c < win_size; c++) begin
                row_sum_d[r] = row_sum_d[r]
                    + acc_w'(taps[r][c]) * acc_w'(kernel_weight(kernel_sel, r, c));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            for (int r = 0; r < win_size; r++) begin
                row_sum_q[r] <= row_sum_d[r];
            end
        end
    end

    // Shift travels with the row sums it belongs to
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_q <= '0;
        end else if (advance) begin
            shift_q <= norm_shift(kernel_sel);
        end
    end

    always_comb begin
        total = '0;
        for (int r = 0; r < win_size; r++) begin
            total = total + row_sum_q[r];
        end
    end

    // Weights sum to 2^shift, so the result fits the channel width
    always_ff @(posedge clk) begin
        if (advance) begin
            chan_out <= chan_w'(total >> shift_q);
        end
    end

endmodule

// File: hdl/pixel_window.sv
`timescale 1ns/1ps

module pixel_window #(
    parameter int IMG_WIDTH = 320
) (
    input  logic clk,
    input  logic rst_n,
    input  logic advance,
    input  logic valid_in,
    input  logic sop_in,
    input  logic eop_in,
    input  logic [blur_pkg::pixel_w-1:0] data_in,
    output logic [blur_pkg::win_size-1:0][blur_pkg::win_size-1:0][blur_pkg::pixel_w-1:0] taps,
    output logic win_valid,
    output logic win_sop,
    output logic win_eop
);
    import blur_pkg::*;

    localparam int col_w = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1;

    // Line buffer j holds the row j+1 above the current one
    logic [pixel_w-1:0] line_buf [win_size-1][IMG_WIDTH];
    logic [win_size-1:0][win_size-1:0][pixel_w-1:0] win;
    logic [pixel_w-1:0] new_col [win_size];
    logic [col_w-1:0] col_cnt;
    logic [col_w-1:0] col_pos;
    logic [col_w-1:0] pix_col;
    logic [2:0] row_cnt;
    logic [2:0] row_pos;
    logic [2:0] pix_row;
    logic accept;
    logic raw_valid;
    logic raw_sop;
    logic raw_eop;

    assign accept = valid_in && advance;

    // Start of packet puts the pixel at the top left corner
    assign col_pos = sop_in ? '0 : col_cnt;
    assign row_pos = sop_in ? '0 : row_cnt;

    always_comb begin
        new_col[0] = data_in;
        for (int j = 1; j < win_size; j++) begin
            new_col[j] = line_buf[j-1][col_pos];
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            line_buf[0][col_pos] <= data_in;
            for (int j = 1; j < win_size - 1; j++) begin
                line_buf[j][col_pos] <= line_buf[j-1][col_pos];
            end
            for (int r = 0; r < win_size; r++) begin
                for (int c = win_size - 1; c > 0; c--) begin
                    win[r][c] <= win[r][c-1];
                end
                win[r][0] <= new_col[r];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
            pix_col <= '0;
            pix_row <= '0;
        end else if (accept) begin
            pix_col <= col_pos;
            pix_row <= row_pos;
            if (col_pos == col_w'(IMG_WIDTH - 1)) begin
                col_cnt <= '0;
                // Only four rows back matter, so the count stops there
                row_cnt <= (row_pos == 3'd4) ? 3'd4 : row_pos + 3'd1;
            end else begin
                col_cnt <= col_pos + 1'b1;
                row_cnt <= row_pos;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            raw_valid <= 1'b0;
            raw_sop <= 1'b0;
            raw_eop <= 1'b0;
            win_valid <= 1'b0;
            win_sop <= 1'b0;
            win_eop <= 1'b0;
        end else if (advance) begin
            raw_valid <= valid_in;
            raw_sop <= valid_in && sop_in;
            raw_eop <= valid_in && eop_in;
            win_valid <= raw_valid;
            win_sop <= raw_sop;
            win_eop <= raw_eop;
        end
    end

    // Zero the taps that fall above the frame or left of the line
    always_ff @(posedge clk) begin
        if (advance) begin
            for (int r = 0; r < win_size; r++) begin
                for (int c = 0; c < win_size; c++) begin
                    if (r > int'(pix_row) || c > int'(pix_col)) begin
                        taps[r][c] <= '0;
                    end else begin
                        taps[r][c] <= win[r][c];
                    end
                end
            end
        end
    end

endmodule

// File: hdl/stream_packer.sv
`timescale 1ns/1ps

module stream_packer (
    input  logic clk,
    input  logic rst_n,
    input  logic win_valid,
    input  logic win_sop,
    input  logic win_eop,
    input  logic [blur_pkg::chan_w-1:0] chan_r,
    input  logic [blur_pkg::chan_w-1:0] chan_g,
    input  logic [blur_pkg::chan_w-1:0] chan_b,
    input  logic ready_out,
    output logic advance,
    output logic valid_out,
    output logic sop_out,
    output logic eop_out,
    output logic [blur_pkg::pixel_w-1:0] data_out
);

    // Marks aligned with convolver stage one and stage two
    logic valid_s1;
    logic sop_s1;
    logic eop_s1;
    logic valid_s2;
    logic sop_s2;
    logic eop_s2;

    // Whole pipeline moves when the output slot is free or being taken
    assign advance = !valid_out || ready_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
            sop_s1 <= 1'b0;
            eop_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            sop_s2 <= 1'b0;
            eop_s2 <= 1'b0;
            valid_out <= 1'b0;
            sop_out <= 1'b0;
            eop_out <= 1'b0;
        end else if (advance) begin
            valid_s1 <= win_valid;
            sop_s1 <= win_sop;
            eop_s1 <= win_eop;
            valid_s2 <= valid_s1;
            sop_s2 <= sop_s1;
            eop_s2 <= eop_s1;
            valid_out <= valid_s2;
            sop_out <= sop_s2;
            eop_out <= eop_s2;
        end
    end

    // Red in the high nibble, as on the input
    always_ff @(posedge clk) begin
        if (advance) begin
            data_out <= {chan_r, chan_g, chan_b};
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build the blur filter testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 -f src.f --top-module blur_filter_tb \
    -o blur_filter_sim

./obj_dir/blur_filter_sim | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

// File: src.f
+incdir+bench
hdl/blur_pkg.sv
hdl/pixel_window.sv
hdl/channel_convolver.sv
hdl/stream_packer.sv
hdl/blur_filter.sv
bench/blur_filter_tb.sv
